// File: logic/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Core data path and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_AW 5

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// Fetch starts here after reset
`define RV_RESET_PC 32'h0000_0000

// Sequential fetch increment in bytes
`define RV_PC_STEP 32'd4

`endif

// File: logic/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;      // Data or byte address
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Major opcodes kept by the core
  typedef enum logic [6:0] {
    OP_LOAD    = 7'b000_0011,
    OP_STORE   = 7'b010_0011,
    OP_BRANCH  = 7'b110_0011,
    OP_JAL     = 7'b110_1111,
    OP_REG_IMM = 7'b001_0011,
    OP_REG_REG = 7'b011_0011,
    OP_LUI     = 7'b011_0111,
    OP_SYSTEM  = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10  // lui result is the U immediate
  } alu_op_e;

  // Multi-cycle sequencer
  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1,
    S_LOAD  = 2'd2,
    S_HALT  = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_we,
  input  wire  rv_pkg::reg_addr_t   i_rd,
  input  wire  rv_pkg::reg_addr_t   i_rs1,
  input  wire  rv_pkg::reg_addr_t   i_rs2,
  input  wire  rv_pkg::word_t       i_rd_data,
  output rv_pkg::word_t             o_rs1_data,
  output rv_pkg::word_t             o_rs2_data
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int idx = 0; idx < `RV_NUM_REGS; idx++) begin
        regs[idx] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin  // x0 never written
      regs[i_rd] <= i_rd_data;
    end
  end

  // Asynchronous read ports
  always_comb begin
    o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];
  end

endmodule

`default_nettype wire

// File: logic/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_ir_load,
  input  wire  rv_pkg::word_t       i_insn,
  output rv_pkg::reg_addr_t         o_rd,
  output rv_pkg::reg_addr_t         o_rs1,
  output rv_pkg::reg_addr_t         o_rs2,
  output logic [2:0]                o_funct3,   // Branch test select
  output rv_pkg::word_t             o_imm,
  output rv_pkg::alu_op_e           o_alu_op,
  output logic                      o_use_imm,
  output logic                      o_is_load,
  output logic                      o_is_store,
  output logic                      o_is_branch,
  output logic                      o_is_jal,
  output logic                      o_is_ecall,
  output logic                      o_writes_rd
);

  rv_pkg::word_t   ir;
  rv_pkg::opcode_e opcode;
  rv_pkg::alu_op_e f3_op;
  logic [2:0]      funct3;
  logic            f7_base;  // funct7 all zero
  logic            f7_alt;   // sub / sra encoding

  // Opcode zero after reset decodes as a no-op
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ir <= '0;
    end else if (i_ir_load) begin
      ir <= i_insn;
    end
  end

  assign opcode   = rv_pkg::opcode_e'(ir[6:0]);
  assign o_rd     = ir[11:7];
  assign o_rs1    = ir[19:15];
  assign o_rs2    = ir[24:20];
  assign funct3   = ir[14:12];
  assign o_funct3 = funct3;
  assign f7_base  = (ir[31:25] == 7'b000_0000);
  assign f7_alt   = (ir[31:25] == 7'b010_0000);

  // Sign-extended immediate per format
  always_comb begin
    case (opcode)
      rv_pkg::OP_LOAD,
      rv_pkg::OP_REG_IMM: o_imm = {{20{ir[31]}}, ir[31:20]};
      rv_pkg::OP_STORE:   o_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      rv_pkg::OP_BRANCH:  o_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      rv_pkg::OP_JAL:     o_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      rv_pkg::OP_LUI:     o_imm = {ir[31:12], 12'b0};
      default:            o_imm = '0;
    endcase
  end

  // Shared funct3 map for both ALU formats
  always_comb begin
    case (funct3)
      3'b000:  f3_op = rv_pkg::ALU_ADD;
      3'b001:  f3_op = rv_pkg::ALU_SLL;
      3'b010:  f3_op = rv_pkg::ALU_SLT;
      3'b011:  f3_op = rv_pkg::ALU_SLTU;
      3'b100:  f3_op = rv_pkg::ALU_XOR;
      3'b101:  f3_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  f3_op = rv_pkg::ALU_OR;
      default: f3_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    o_alu_op    = rv_pkg::ALU_ADD;  // Also the load/store address add
    o_use_imm   = 1'b0;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_ecall  = 1'b0;
    o_writes_rd = 1'b0;
    case (opcode)
      rv_pkg::OP_LOAD: begin
        if (funct3 == 3'b010) begin  // lw only
          o_use_imm   = 1'b1;
          o_is_load   = 1'b1;
          o_writes_rd = 1'b1;
        end
      end
      rv_pkg::OP_STORE: begin
        o_use_imm  = (funct3 == 3'b010);
        o_is_store = (funct3 == 3'b010);
      end
      rv_pkg::OP_BRANCH: begin
        o_alu_op    = rv_pkg::ALU_SUB;
        o_is_branch = (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101});
      end
      rv_pkg::OP_JAL: begin
        o_is_jal    = 1'b1;
        o_writes_rd = 1'b1;  // Link value comes from the PC
      end
      rv_pkg::OP_LUI: begin
        o_alu_op    = rv_pkg::ALU_PASS_B;
        o_use_imm   = 1'b1;
        o_writes_rd = 1'b1;
      end
      rv_pkg::OP_REG_IMM: begin
        // Shift immediates carry funct7 in the upper bits
        if ((funct3 == 3'b001 && f7_base) ||
            (funct3 == 3'b101 && (f7_base || f7_alt)) ||
            (funct3 != 3'b001 && funct3 != 3'b101)) begin
          o_alu_op    = f3_op;
          o_use_imm   = 1'b1;
          o_writes_rd = 1'b1;
        end
      end
      rv_pkg::OP_REG_REG: begin
        if (f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          o_alu_op    = (f7_alt && funct3 == 3'b000) ? rv_pkg::ALU_SUB : f3_op;
          o_writes_rd = 1'b1;
        end
      end
      rv_pkg::OP_SYSTEM: o_is_ecall = (ir[31:7] == '0);
      default:           o_writes_rd = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  wire  rv_pkg::word_t     i_a,
  input  wire  rv_pkg::word_t     i_b,
  input  wire  rv_pkg::alu_op_e   i_op,
  input  wire  [2:0]              i_funct3,
  output rv_pkg::word_t           o_result,
  output logic                    o_take
);

  logic [4:0] shamt;
  logic       equal;
  logic       less;    // Signed, shared by slt and blt/bge
  logic       less_u;

  assign shamt  = i_b[4:0];  // Only the low five bits shift
  assign equal  = (i_a == i_b);
  assign less   = ($signed(i_a) < $signed(i_b));
  assign less_u = (i_a < i_b);

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:    o_result = i_a + i_b;
      rv_pkg::ALU_SUB:    o_result = i_a - i_b;
      rv_pkg::ALU_AND:    o_result = i_a & i_b;
      rv_pkg::ALU_OR:     o_result = i_a | i_b;
      rv_pkg::ALU_XOR:    o_result = i_a ^ i_b;
      rv_pkg::ALU_SLT:    o_result = rv_pkg::word_t'(less);
      rv_pkg::ALU_SLTU:   o_result = rv_pkg::word_t'(less_u);
      rv_pkg::ALU_SLL:    o_result = i_a << shamt;
      rv_pkg::ALU_SRL:    o_result = i_a >> shamt;
      rv_pkg::ALU_SRA:    o_result = rv_pkg::word_t'($signed(i_a) >>> shamt);
      rv_pkg::ALU_PASS_B: o_result = i_b;
      default:            o_result = '0;
    endcase
  end

  // Branch test on the same operands
  always_comb begin
    case (i_funct3)
      3'b000:  o_take = equal;   // beq
      3'b001:  o_take = !equal;  // bne
      3'b100:  o_take = less;    // blt
      3'b101:  o_take = !less;   // bge
      default: o_take = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_pc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_pc (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_en,
  input  wire                   i_branch,
  input  wire                   i_take,
  input  wire                   i_jal,
  input  wire  rv_pkg::word_t   i_imm,
  output rv_pkg::word_t         o_pc,
  output rv_pkg::word_t         o_pc_plus
);

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pc_next;

  assign o_pc_plus = pc_q + `RV_PC_STEP;  // Also jal link value

  // PC-relative target for jal or a taken branch
  always_comb begin
    if (i_jal || (i_branch && i_take)) begin
      pc_next = pc_q + i_imm;
    end else begin
      pc_next = o_pc_plus;
    end
  end

  // Look-ahead so the registered imem has the next word by S_FETCH
  assign o_pc = i_en ? pc_next : pc_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else if (i_en) begin
      pc_q <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module rv_sequencer (
  input  wire   clk,
  input  wire   rst,
  input  wire   i_is_load,
  input  wire   i_is_store,
  input  wire   i_is_ecall,
  input  wire   i_writes_rd,
  output logic  o_ir_load,
  output logic  o_pc_en,
  output logic  o_rf_we,
  output logic  o_dmem_we,
  output logic  o_dmem_re,
  output logic  o_halt
);

  rv_pkg::seq_state_e state;
  rv_pkg::seq_state_e state_next;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= rv_pkg::S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    o_ir_load  = 1'b0;
    o_pc_en    = 1'b0;
    o_rf_we    = 1'b0;
    o_dmem_we  = 1'b0;
    o_dmem_re  = 1'b0;
    case (state)
      rv_pkg::S_FETCH: begin
        o_ir_load  = 1'b1;  // Instruction word is valid this cycle
        state_next = rv_pkg::S_EXEC;
      end
      rv_pkg::S_EXEC: begin
        if (i_is_ecall) begin
          state_next = rv_pkg::S_HALT;  // PC stays on the ecall
        end else if (i_is_load) begin
          o_dmem_re  = 1'b1;
          state_next = rv_pkg::S_LOAD;
        end else begin
          o_pc_en    = 1'b1;
          o_rf_we    = i_writes_rd;
          o_dmem_we  = i_is_store;
          state_next = rv_pkg::S_FETCH;
        end
      end
      rv_pkg::S_LOAD: begin
        // Read data arrived, retire the load
        o_pc_en    = 1'b1;
        o_rf_we    = i_writes_rd;
        state_next = rv_pkg::S_FETCH;
      end
      default: state_next = rv_pkg::S_HALT;  // Held until reset
    endcase
  end

  assign o_halt = (state == rv_pkg::S_HALT);

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  wire                   clk,
  input  wire                   rst,
  output rv_pkg::word_t         o_imem_addr,
  input  wire  rv_pkg::word_t   i_imem_data,
  output rv_pkg::word_t         o_dmem_addr,
  output rv_pkg::word_t         o_dmem_wdata,
  output logic                  o_dmem_we,
  output logic                  o_dmem_re,
  input  wire  rv_pkg::word_t   i_dmem_rdata,
  output logic                  o_halt
);

  logic              ir_load, pc_en, rf_we;
  rv_pkg::reg_addr_t rd, rs1, rs2;
  logic [2:0]        funct3;
  rv_pkg::word_t     imm;
  rv_pkg::alu_op_e   alu_op;
  logic              use_imm, is_load, is_store, is_branch, is_jal, is_ecall, writes_rd;
  rv_pkg::word_t     rs1_data, rs2_data;
  rv_pkg::word_t     alu_b, alu_result;
  logic              take;
  rv_pkg::word_t     pc, pc_plus;
  rv_pkg::word_t     wb_data;

  rv_sequencer u_seq (
    .clk(clk), .rst(rst),
    .i_is_load(is_load), .i_is_store(is_store),
    .i_is_ecall(is_ecall), .i_writes_rd(writes_rd),
    .o_ir_load(ir_load), .o_pc_en(pc_en), .o_rf_we(rf_we),
    .o_dmem_we(o_dmem_we), .o_dmem_re(o_dmem_re), .o_halt(o_halt)
  );

  rv_pc u_pc (
    .clk(clk), .rst(rst), .i_en(pc_en),
    .i_branch(is_branch), .i_take(take), .i_jal(is_jal),
    .i_imm(imm), .o_pc(pc), .o_pc_plus(pc_plus)
  );

  rv_decoder u_dec (
    .clk(clk), .rst(rst), .i_ir_load(ir_load), .i_insn(i_imem_data),
    .o_rd(rd), .o_rs1(rs1), .o_rs2(rs2), .o_funct3(funct3),
    .o_imm(imm), .o_alu_op(alu_op), .o_use_imm(use_imm),
    .o_is_load(is_load), .o_is_store(is_store), .o_is_branch(is_branch),
    .o_is_jal(is_jal), .o_is_ecall(is_ecall), .o_writes_rd(writes_rd)
  );

  rv_regfile u_rf (
    .clk(clk), .rst(rst), .i_we(rf_we),
    .i_rd(rd), .i_rs1(rs1), .i_rs2(rs2), .i_rd_data(wb_data),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  rv_alu u_alu (
    .i_a(rs1_data), .i_b(alu_b), .i_op(alu_op), .i_funct3(funct3),
    .o_result(alu_result), .o_take(take)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  // Load data only meaningful in S_LOAD
  assign wb_data = is_load ? i_dmem_rdata :
                   is_jal  ? pc_plus      : alu_result;

  assign o_imem_addr  = pc;  // Next fetch address
  assign o_dmem_addr  = (is_load || is_store) ? alu_result : '0;
  assign o_dmem_wdata = rs2_data;

endmodule

`default_nettype wire

// File: tests/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic rv_pkg::word_t rand_bits(input int n);
  rv_pkg::word_t v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

function automatic logic [4:0] pick_reg();
  return 5'(rand_bits(3) % 7 + 1);  // x1 to x7
endfunction

// I format, also R format with {funct7, rs2} in the immediate slot
function automatic rv_pkg::word_t imm_insn(rv_pkg::opcode_e op, logic [4:0] rd,
                                           logic [2:0] f3, logic [4:0] rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t store_insn(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
endfunction

function automatic rv_pkg::word_t branch_insn(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                              logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
endfunction

function automatic rv_pkg::word_t jump_insn(logic [4:0] rd, logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
endfunction

task automatic put_word(input rv_pkg::word_t insn);
  image[prog_len] = insn;
  prog_len++;
endtask

// Random ALU instruction in register or immediate form
task automatic add_alu_op(input logic imm_form);
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] shamt;
  logic [2:0] f3;
  logic [6:0] f7;
  rd = pick_reg();
  rs1 = pick_reg();
  rs2 = pick_reg();
  shamt = 5'(rand_bits(5));
  f3 = 3'(rand_bits(3));
  f7 = 7'h00;
  // sub, sra and srai use the alternate funct7
  if ((f3 == 3'b101 || (f3 == 3'b000 && !imm_form)) && rand_bits(1) != 0) begin
    f7 = 7'h20;
  end
  if (!imm_form) begin
    put_word(imm_insn(rv_pkg::OP_REG_REG, rd, f3, rs1, {f7, rs2}));
  end else if (f3 == 3'b001 || f3 == 3'b101) begin
    put_word(imm_insn(rv_pkg::OP_REG_IMM, rd, f3, rs1, {f7, shamt}));
  end else begin
    put_word(imm_insn(rv_pkg::OP_REG_IMM, rd, f3, rs1, 12'(rand_bits(12))));
  end
endtask

task automatic build_program();
  logic [4:0] r;
  logic [2:0] f3;
  prog_len = 0;
  for (int i = 0; i < MEM_WORDS; i++) begin
    image[i] = '0;
  end
  for (int k = 256; k < 320; k++) begin
    image[k] = rand_bits(32);  // Load data at 0x400
  end
  for (int x = 1; x < 8; x++) begin
    put_word({20'(rand_bits(20)), 5'(x), rv_pkg::OP_LUI});
    put_word(imm_insn(rv_pkg::OP_REG_IMM, 5'(x), 3'b000, 5'(x), 12'(rand_bits(12))));
  end
  for (int n = 0; n < 24; n++) begin
    case (rand_bits(2))
      0: add_alu_op(1'b0);
      1: add_alu_op(1'b1);
      2: begin
        r = pick_reg();
        f3 = 3'(rand_bits(2));
        f3 = {f3[1], 1'b0, f3[0]};  // beq, bne, blt, bge
        put_word(branch_insn(f3, r, (rand_bits(1) != 0) ? r : pick_reg(), 13'd8));
        add_alu_op(1'b1);  // Skipped when taken
      end
      default: begin
        if (rand_bits(1) != 0) begin
          r = pick_reg();
          put_word(imm_insn(rv_pkg::OP_LOAD, r, 3'b010, 5'd0, 12'(32'h400 + 4 * rand_bits(6))));
        end else begin
          put_word(jump_insn(pick_reg(), 21'd8));
          add_alu_op(1'b0);
        end
      end
    endcase
  end
  put_word(jump_insn(5'd6, 21'd8));
  put_word(imm_insn(rv_pkg::OP_REG_IMM, 5'd6, 3'b000, 5'd0, 12'h7FF));
  put_word(imm_insn(rv_pkg::OP_REG_IMM, 5'd0, 3'b000, 5'd1, 12'h055));  // Write to x0
  for (int x = 0; x < 8; x++) begin
    put_word(store_insn(5'(x), 5'd0, 12'(32'h600 + 4 * x)));
  end
  put_word(32'h0000_0073);  // ecall
endtask

function automatic rv_pkg::word_t alu_model(logic [2:0] f3, logic [6:0] f7, rv_pkg::word_t a,
                                            rv_pkg::word_t b, logic reg_form);
  case (f3)
    3'b000: return (reg_form && f7 == 7'h20) ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return {31'b0, $signed(a) < $signed(b)};
    3'b011: return {31'b0, a < b};
    3'b100: return a ^ b;
    3'b101: return (f7 == 7'h20) ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

// ISA level model of the program, returns the PC of the ecall
function automatic rv_pkg::word_t run_reference();
  rv_pkg::word_t pc, nxt, insn, a, b, ea, res, imm_i;
  logic [4:0]    rd;
  logic [2:0]    f3;
  logic          wr;
  ref_halted = 1'b0;
  pc = `RV_RESET_PC;
  for (int i = 0; i < 32; i++) begin
    ref_rf[i] = '0;
  end
  for (int i = 0; i < MEM_WORDS; i++) begin
    ref_mem[i] = image[i];
  end
  for (int step = 0; step < 4096 && !ref_halted; step++) begin
    insn = ref_mem[pc[11:2]];
    rd = insn[11:7];
    f3 = insn[14:12];
    a = ref_rf[insn[19:15]];
    b = ref_rf[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    nxt = pc + 4;
    wr = 1'b1;
    res = '0;
    case (insn[6:0])
      rv_pkg::OP_LUI:     res = {insn[31:12], 12'b0};
      rv_pkg::OP_REG_IMM: res = alu_model(f3, insn[31:25], a, imm_i, 1'b0);
      rv_pkg::OP_REG_REG: res = alu_model(f3, insn[31:25], a, b, 1'b1);
      rv_pkg::OP_LOAD: begin
        ea = a + imm_i;
        res = ref_mem[ea[11:2]];
      end
      rv_pkg::OP_STORE: begin
        ea = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
        ref_mem[ea[11:2]] = b;
        exp_addr.push_back(ea);
        exp_data.push_back(b);
        exp_pc.push_back(pc);
        wr = 1'b0;
      end
      rv_pkg::OP_BRANCH: begin
        // funct3 bit 0 inverts the equal or less-than test
        if (f3[2] ? (($signed(a) < $signed(b)) ^ f3[0]) : ((a == b) ^ f3[0])) begin
          nxt = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        end
        wr = 1'b0;
      end
      rv_pkg::OP_JAL: begin
        res = pc + 4;
        nxt = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      default: begin
        ref_halted = (insn == 32'h0000_0073);
        wr = 1'b0;
      end
    endcase
    if (wr && rd != 5'd0) begin
      ref_rf[rd] = res;
    end
    if (!ref_halted) begin
      pc = nxt;
    end
  end
  return pc;
endfunction

`endif

// File: tests/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module tb_core;

  localparam int MEM_WORDS    = 1024;
  localparam int HALT_TIMEOUT = 4000;

  logic          clk;
  logic          rst;
  rv_pkg::word_t imem_addr;
  rv_pkg::word_t imem_data;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  logic          dmem_we;
  logic          dmem_re;
  rv_pkg::word_t dmem_rdata;
  logic          halt;

  rv_pkg::word_t mem [MEM_WORDS];      // Memory seen by the DUT
  rv_pkg::word_t image [MEM_WORDS];    // Program and data as built
  rv_pkg::word_t ref_mem [MEM_WORDS];
  rv_pkg::word_t ref_rf [32];
  rv_pkg::word_t exp_addr [$];
  rv_pkg::word_t exp_data [$];
  rv_pkg::word_t exp_pc [$];
  rv_pkg::word_t halt_pc;
  logic [15:0]   lfsr_state;
  logic          ref_halted;
  int            prog_len;
  int            store_idx;
  int            cycle = 0;
  int            last_store_cycle;
  int            value_errors;
  int            other_errors;

  `include "tb_ref.svh"

  rv_core rv_core_inst (
    .clk(clk), .rst(rst),
    .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
    .o_dmem_we(dmem_we), .o_dmem_re(dmem_re), .i_dmem_rdata(dmem_rdata),
    .o_halt(halt)
  );

  always #4 clk = ~clk;

  // Both ports answer one clock after the request
  always @(posedge clk) begin
    imem_data <= mem[imem_addr[11:2]];
    if (dmem_re) begin
      dmem_rdata <= mem[dmem_addr[11:2]];
    end
    if (dmem_we) begin
      mem[dmem_addr[11:2]] <= dmem_wdata;
    end
    cycle <= cycle + 1;
  end

  task automatic store_addr_check(input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error o_dmem_addr: got %h expected %h (store %0d)", got, exp, store_idx);
      value_errors++;
    end
  endtask

  task automatic store_data_check(input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error o_dmem_wdata: got %h expected %h (store %0d)", got, exp, store_idx);
      value_errors++;
    end
  endtask

  task automatic fetch_addr_check(input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error o_imem_addr: got %h expected %h", got, exp);
      value_errors++;
    end
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error %s: got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // Store pulses against the reference sequence
  always @(negedge clk) begin
    if (!rst && dmem_we) begin
      if (store_idx >= exp_addr.size()) begin
        $display("Store to address %h came after the expected stores ended", dmem_addr);
        other_errors++;
      end else begin
        store_addr_check(dmem_addr, exp_addr[store_idx]);
        store_data_check(dmem_wdata, exp_data[store_idx]);
        if (store_idx > 0 && exp_pc[store_idx] == exp_pc[store_idx - 1] + 4 &&
            cycle - last_store_cycle != 2) begin  // Adjacent sw retire two cycles apart
          $display("Store %0d came %0d cycles after the previous one instead of 2",
                   store_idx, cycle - last_store_cycle);
          other_errors++;
        end
      end
      last_store_cycle = cycle;
      store_idx++;
    end
  end

  initial begin
    int wait_cycles;
    clk = 1'b0;
    rst <= 1'b1;
    imem_data <= '0;
    dmem_rdata <= '0;
    lfsr_state = 16'd45826;
    store_idx = 0;
    last_store_cycle = 0;
    value_errors = 0;
    other_errors = 0;
    build_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= image[i];
    end
    halt_pc = run_reference();
    if (!ref_halted) begin
      $display("Reference model never reached the ecall");
      other_errors++;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    flag_check("o_dmem_we", dmem_we, 1'b0);
    flag_check("o_dmem_re", dmem_re, 1'b0);
    flag_check("o_halt", halt, 1'b0);
    fetch_addr_check(imem_addr, `RV_RESET_PC);
    wait_cycles = 0;
    while (!halt && wait_cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!halt) begin
      $display("Core did not halt within %0d cycles", HALT_TIMEOUT);
      other_errors++;
    end else begin
      // Halt must hold with the fetch address parked on the ecall
      for (int k = 0; k < 6; k++) begin
        @(negedge clk);
        flag_check("o_halt", halt, 1'b1);
        fetch_addr_check(imem_addr, halt_pc);
      end
    end
    if (store_idx != exp_addr.size()) begin
      $display("Core made %0d stores where the reference made %0d", store_idx, exp_addr.size());
      other_errors++;
    end
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
+incdir+tests
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_pc.sv
logic/rv_sequencer.sv
logic/rv_core.sv
tests/tb_core.sv

// File: Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -f vlog.f --top-module rv_core

sim:
	verilator --binary --timing -f vlog.f --top-module tb_core -o tb_core_sim
	./obj_dir/tb_core_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test passed" $(LOG)
	! grep -q "Test failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
